// ==== f8_pkg.sv ====
package f8_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [15:0] word_t;
	typedef logic [14:0] bank_addr_t;

	localparam word_t RESET_VECTOR_DEFAULT = 16'h4000;

	typedef enum logic [7:0]
	{
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		OP_LD_XL_IMMD = 8'h10,
		OP_LD_XL_DIR = 8'h11,
		OP_LD_XL_IY = 8'h12,
		OP_LD_DIR_XL = 8'h13,
		OP_LD_IY_XL = 8'h14,
		OP_ADD_XL_IMMD = 8'h20,
		OP_SUB_XL_IMMD = 8'h21,
		OP_AND_XL_IMMD = 8'h22,
		OP_OR_XL_IMMD = 8'h23,
		OP_XOR_XL_IMMD = 8'h24,
		OP_ADD_XL_DIR = 8'h25,
		OP_INC_XL = 8'h30,
		OP_DEC_XL = 8'h31,
		OP_SRL_XL = 8'h32,
		OP_SLL_XL = 8'h33,
		OP_LDW_Y_IMMD = 8'h40,
		OP_INCW_Y = 8'h41,
		OP_LDW_DIR_Y = 8'h42,
		OP_JP_IMMD = 8'h50,
		OP_JR_D = 8'h51,
		OP_JRZ_D = 8'h52,
		OP_JRNZ_D = 8'h53,
		OP_JRC_D = 8'h54,
		OP_JRNC_D = 8'h55
	} opcode_t;

	typedef enum logic [3:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_INC,
		ALU_DEC,
		ALU_SRL,
		ALU_SLL,
		ALU_INCW,
		ALU_PASS
	} alu_op_t;

	typedef struct packed
	{
		logic o;
		logic z;
		logic n;
		logic c;
	} flags_t;

	typedef struct packed
	{
		word_t result;
		logic c;
		logic o;
		logic z;
		logic n;
	} addsub_result_t;

	function automatic logic [1:0] inst_size(opcode_t op);
		case (op)
			OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD,
			OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_JR_D, OP_JRZ_D, OP_JRNZ_D,
			OP_JRC_D, OP_JRNC_D:
				return 2'd2;
			OP_LD_XL_DIR, OP_LD_DIR_XL, OP_ADD_XL_DIR, OP_LDW_Y_IMMD,
			OP_LDW_DIR_Y, OP_JP_IMMD:
				return 2'd3;
			default:
				return 2'd1;
		endcase
	endfunction

	function automatic logic loads_upper(opcode_t op);
		return inst_size(op) == 2'd3;
	endfunction

	function automatic logic loads_operand(opcode_t op);
		return op == OP_LD_XL_DIR || op == OP_LD_XL_IY || op == OP_ADD_XL_DIR;
	endfunction

	// subtract is a + ~b + 1, so c means no borrow
	function automatic addsub_result_t addsub(word_t a, word_t b, logic cin, logic wide);
		addsub_result_t r;
		logic [16:0] sum16;
		logic [8:0] sum8;
		sum16 = {1'b0, a} + {1'b0, b} + {16'h0000, cin};
		sum8 = {1'b0, a[7:0]} + {1'b0, b[7:0]} + {8'h00, cin};
		if (wide)
		begin
			r.result = sum16[15:0];
			r.c = sum16[16];
			r.o = (a[15] == b[15]) && (sum16[15] != a[15]);
			r.z = (sum16[15:0] == 16'h0000);
			r.n = sum16[15];
		end
		else
		begin
			r.result = {8'h00, sum8[7:0]};
			r.c = sum8[8];
			r.o = (a[7] == b[7]) && (sum8[7] != a[7]);
			r.z = (sum8[7:0] == 8'h00);
			r.n = sum8[7];
		end
		return r;
	endfunction

endpackage

// ==== f8_ifs.sv ====
interface mem_access_if (input logic clk);
	import f8_pkg::*;

	word_t read_addr;
	word_t read_word;
	word_t write_addr;
	word_t write_data;
	logic [1:0] write_en;

	modport fetch_mp (output read_addr, input read_word);
	modport exec_mp (output write_addr, output write_data, output write_en);
	modport port_mp (input clk, input read_addr, output read_word,
		input write_addr, input write_data, input write_en);
endinterface

interface reg_update_if;
	import f8_pkg::*;

	// reg_sel 0 is x, 1 is y
	logic reg_sel;
	word_t reg_data;
	logic [1:0] reg_en;
	flags_t next_f;
	word_t next_pc;

	modport exec_mp (output reg_sel, output reg_data, output reg_en,
		output next_f, output next_pc);
	modport regs_mp (input reg_sel, input reg_data, input reg_en,
		input next_f, input next_pc);
endinterface

// ==== f8_regfile.sv ====
module f8_regfile #(
	parameter f8_pkg::word_t RESET_VECTOR = f8_pkg::RESET_VECTOR_DEFAULT
) (
	input logic clk,
	input logic reset,
	reg_update_if.regs_mp upd,
	output f8_pkg::word_t x,
	output f8_pkg::word_t y,
	output f8_pkg::word_t pc,
	output f8_pkg::flags_t f
);
	import f8_pkg::*;

	word_t gp[2];

	assign x = gp[0];
	assign y = gp[1];

	// byte lanes written separately
	always_ff @(posedge clk)
	begin
		if (upd.reg_en[0])
			gp[upd.reg_sel][7:0] <= upd.reg_data[7:0];
		if (upd.reg_en[1])
			gp[upd.reg_sel][15:8] <= upd.reg_data[15:8];
	end

	// pc follows execute every cycle, it holds by itself when nothing executes
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			f <= '0;
			pc <= RESET_VECTOR;
		end
		else
		begin
			f <= upd.next_f;
			pc <= upd.next_pc;
		end
	end

endmodule

// ==== f8_mem_port.sv ====
module f8_mem_port (
	mem_access_if.port_mp bus,
	output f8_pkg::bank_addr_t mem_read_addr_even,
	output f8_pkg::bank_addr_t mem_read_addr_odd,
	input f8_pkg::byte_t mem_read_data_even,
	input f8_pkg::byte_t mem_read_data_odd,
	output f8_pkg::bank_addr_t mem_write_addr_even,
	output f8_pkg::bank_addr_t mem_write_addr_odd,
	output f8_pkg::byte_t mem_write_data_even,
	output f8_pkg::byte_t mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd
);
	import f8_pkg::*;

	bank_addr_t rd_word;
	bank_addr_t wr_word;
	logic rd_odd;
	logic wr_odd;

	assign rd_word = bus.read_addr[15:1];
	assign wr_word = bus.write_addr[15:1];
	assign wr_odd = bus.write_addr[0];

	// odd access: low byte in the odd bank, high byte in the next even word
	assign mem_read_addr_odd = rd_word;
	assign mem_read_addr_even = bus.read_addr[0] ? rd_word + 15'd1 : rd_word;

	// lane order of the data coming back next cycle
	always_ff @(posedge bus.clk)
	begin
		rd_odd <= bus.read_addr[0];
	end

	assign bus.read_word = rd_odd ? {mem_read_data_even, mem_read_data_odd}
		: {mem_read_data_odd, mem_read_data_even};

	assign mem_write_addr_odd = wr_word;
	assign mem_write_addr_even = wr_odd ? wr_word + 15'd1 : wr_word;
	assign mem_write_data_even = wr_odd ? bus.write_data[15:8] : bus.write_data[7:0];
	assign mem_write_data_odd = wr_odd ? bus.write_data[7:0] : bus.write_data[15:8];
	assign mem_write_en_even = wr_odd ? bus.write_en[1] : bus.write_en[0];
	assign mem_write_en_odd = wr_odd ? bus.write_en[0] : bus.write_en[1];

endmodule

// ==== f8_fetch.sv ====
module f8_fetch (
	input logic clk,
	input logic reset,
	mem_access_if.fetch_mp bus,
	input f8_pkg::word_t pc,
	input f8_pkg::word_t y,
	input f8_pkg::word_t next_pc,
	output logic [23:0] inst,
	output f8_pkg::word_t operand,
	output logic execute
);
	import f8_pkg::*;

	logic [23:0] pending;
	logic upper_valid;
	logic operand_loaded;
	logic started;
	logic loading_upper;
	logic loading_operand;
	opcode_t op;
	word_t operand_addr;

	// first cycle after reset only fetches from the reset vector
	always_comb
	begin
		if (!started)
			inst = pending;
		else if (upper_valid)
			inst = {bus.read_word[7:0], pending[15:0]};
		else if (operand_loaded)
			inst = pending;
		else
			inst = {8'h00, bus.read_word};
	end

	assign op = opcode_t'(inst[7:0]);
	assign operand = bus.read_word;

	assign execute = started && (!loads_upper(op) || upper_valid || operand_loaded)
		&& (!loads_operand(op) || operand_loaded);
	assign loading_upper = loads_upper(op) && !upper_valid && !execute;
	assign loading_operand = loads_operand(op) && !loading_upper && !execute;

	assign operand_addr = (op == OP_LD_XL_IY) ? y : inst[23:8];

	// upper byte sits at pc+2, the next instruction at next_pc
	always_comb
	begin
		if (loading_upper)
			bus.read_addr = pc + 16'd2;
		else if (loading_operand)
			bus.read_addr = operand_addr;
		else
			bus.read_addr = next_pc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pending <= {16'h0000, OP_NOP};
			upper_valid <= 1'b0;
			operand_loaded <= 1'b0;
			started <= 1'b0;
		end
		else
		begin
			pending <= inst;
			upper_valid <= loading_upper;
			operand_loaded <= loading_operand;
			started <= 1'b1;
		end
	end

endmodule

// ==== f8_alu.sv ====
module f8_alu (
	input f8_pkg::alu_op_t op,
	input f8_pkg::word_t a,
	input f8_pkg::word_t b,
	input f8_pkg::flags_t f_in,
	output f8_pkg::word_t result,
	output f8_pkg::flags_t f_out
);
	import f8_pkg::*;

	addsub_result_t sum;
	byte_t logic8;
	byte_t shift8;

	always_comb
	begin
		case (op)
			ALU_SUB: sum = addsub(a, ~b, 1'b1, 1'b0);
			ALU_INC: sum = addsub(a, 16'h0001, 1'b0, 1'b0);
			// a + 0xfe + 1
			ALU_DEC: sum = addsub(a, 16'h00fe, 1'b1, 1'b0);
			ALU_INCW: sum = addsub(a, 16'h0001, 1'b0, 1'b1);
			default: sum = addsub(a, b, 1'b0, 1'b0);
		endcase
	end

	always_comb
	begin
		case (op)
			ALU_AND: logic8 = a[7:0] & b[7:0];
			ALU_OR: logic8 = a[7:0] | b[7:0];
			ALU_XOR: logic8 = a[7:0] ^ b[7:0];
			default: logic8 = b[7:0];
		endcase
	end

	assign shift8 = (op == ALU_SRL) ? {1'b0, a[7:1]} : {a[6:0], 1'b0};

	always_comb
	begin
		result = sum.result;
		f_out = f_in;
		case (op)
			ALU_ADD, ALU_SUB, ALU_INC, ALU_DEC, ALU_INCW:
			begin
				f_out.o = sum.o;
				f_out.z = sum.z;
				f_out.n = sum.n;
				f_out.c = sum.c;
			end
			ALU_AND, ALU_OR, ALU_XOR, ALU_PASS:
			begin
				result = {8'h00, logic8};
				f_out.z = ~|logic8;
				f_out.n = logic8[7];
			end
			ALU_SRL, ALU_SLL:
			begin
				result = {8'h00, shift8};
				f_out.z = ~|shift8;
				// bit shifted out
				f_out.c = (op == ALU_SRL) ? a[0] : a[7];
			end
		endcase
	end

endmodule

// ==== f8_execute.sv ====
module f8_execute (
	input logic [23:0] inst,
	input f8_pkg::word_t operand,
	input logic execute,
	input f8_pkg::word_t x,
	input f8_pkg::word_t y,
	input f8_pkg::word_t pc,
	input f8_pkg::flags_t f,
	mem_access_if.exec_mp bus,
	reg_update_if.exec_mp upd,
	output logic trap
);
	import f8_pkg::*;

	opcode_t op;
	byte_t imm8;
	word_t imm16;
	alu_op_t alu_op;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	flags_t alu_f;
	logic alu_sets_flags;
	logic jr_taken;

	assign op = opcode_t'(inst[7:0]);
	assign imm8 = inst[15:8];
	assign imm16 = inst[23:8];

	// immediate loads and stores leave the flags alone
	always_comb
	begin
		alu_op = ALU_PASS;
		alu_a = x;
		alu_b = {8'h00, imm8};
		alu_sets_flags = 1'b1;
		case (op)
			OP_LD_XL_DIR, OP_LD_XL_IY: alu_b = operand;
			OP_ADD_XL_IMMD: alu_op = ALU_ADD;
			OP_SUB_XL_IMMD: alu_op = ALU_SUB;
			OP_AND_XL_IMMD: alu_op = ALU_AND;
			OP_OR_XL_IMMD: alu_op = ALU_OR;
			OP_XOR_XL_IMMD: alu_op = ALU_XOR;
			OP_ADD_XL_DIR:
			begin
				alu_op = ALU_ADD;
				alu_b = operand;
			end
			OP_INC_XL: alu_op = ALU_INC;
			OP_DEC_XL: alu_op = ALU_DEC;
			OP_SRL_XL: alu_op = ALU_SRL;
			OP_SLL_XL: alu_op = ALU_SLL;
			OP_INCW_Y:
			begin
				alu_op = ALU_INCW;
				alu_a = y;
			end
			default: alu_sets_flags = 1'b0;
		endcase
	end

	f8_alu alu_i (
		.op(alu_op),
		.a(alu_a),
		.b(alu_b),
		.f_in(f),
		.result(alu_result),
		.f_out(alu_f)
	);

	always_comb
	begin
		upd.reg_sel = 1'b0;
		upd.reg_data = alu_result;
		upd.reg_en = 2'b00;
		bus.write_addr = imm16;
		bus.write_data = {8'h00, x[7:0]};
		bus.write_en = 2'b00;
		if (execute)
		begin
			case (op)
				OP_LD_XL_IMMD:
				begin
					upd.reg_data = {imm8, imm8};
					upd.reg_en = 2'b01;
				end
				OP_LD_XL_DIR, OP_LD_XL_IY, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD,
				OP_AND_XL_IMMD, OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_ADD_XL_DIR,
				OP_INC_XL, OP_DEC_XL, OP_SRL_XL, OP_SLL_XL:
					upd.reg_en = 2'b01;
				OP_LDW_Y_IMMD:
				begin
					upd.reg_sel = 1'b1;
					upd.reg_data = imm16;
					upd.reg_en = 2'b11;
				end
				OP_INCW_Y:
				begin
					upd.reg_sel = 1'b1;
					upd.reg_en = 2'b11;
				end
				OP_LD_DIR_XL: bus.write_en = 2'b01;
				OP_LD_IY_XL:
				begin
					bus.write_addr = y;
					bus.write_en = 2'b01;
				end
				OP_LDW_DIR_Y:
				begin
					bus.write_data = y;
					bus.write_en = 2'b11;
				end
				default: ;
			endcase
		end
	end

	assign upd.next_f = (execute && alu_sets_flags) ? alu_f : f;

	always_comb
	begin
		case (op)
			OP_JR_D: jr_taken = 1'b1;
			OP_JRZ_D: jr_taken = f.z;
			OP_JRNZ_D: jr_taken = !f.z;
			OP_JRC_D: jr_taken = f.c;
			OP_JRNC_D: jr_taken = !f.c;
			default: jr_taken = 1'b0;
		endcase
	end

	// displacement counts from the jr opcode itself
	always_comb
	begin
		if (!execute || op == OP_TRAP)
			upd.next_pc = pc;
		else if (op == OP_JP_IMMD)
			upd.next_pc = imm16;
		else if (jr_taken)
			upd.next_pc = pc + {{8{imm8[7]}}, imm8};
		else
			upd.next_pc = pc + {14'd0, inst_size(op)};
	end

	assign trap = execute && (op == OP_TRAP);

endmodule

// ==== f8_core.sv ====
module f8_core #(
	parameter f8_pkg::word_t RESET_VECTOR = f8_pkg::RESET_VECTOR_DEFAULT
) (
	input logic clk,
	input logic reset,
	output f8_pkg::bank_addr_t mem_read_addr_even,
	output f8_pkg::bank_addr_t mem_read_addr_odd,
	input f8_pkg::byte_t mem_read_data_even,
	input f8_pkg::byte_t mem_read_data_odd,
	output f8_pkg::bank_addr_t mem_write_addr_even,
	output f8_pkg::bank_addr_t mem_write_addr_odd,
	output f8_pkg::byte_t mem_write_data_even,
	output f8_pkg::byte_t mem_write_data_odd,
	output logic mem_write_en_even,
	output logic mem_write_en_odd,
	output logic trap
);
	import f8_pkg::*;

	word_t x;
	word_t y;
	word_t pc;
	flags_t f;
	logic [23:0] inst;
	word_t operand;
	logic execute;

	mem_access_if mem_bus (.clk(clk));
	reg_update_if reg_upd ();

	f8_regfile #(
		.RESET_VECTOR(RESET_VECTOR)
	) regfile_i (
		.clk(clk),
		.reset(reset),
		.upd(reg_upd.regs_mp),
		.x(x),
		.y(y),
		.pc(pc),
		.f(f)
	);

	f8_mem_port mem_port_i (
		.bus(mem_bus.port_mp),
		.mem_read_addr_even(mem_read_addr_even),
		.mem_read_addr_odd(mem_read_addr_odd),
		.mem_read_data_even(mem_read_data_even),
		.mem_read_data_odd(mem_read_data_odd),
		.mem_write_addr_even(mem_write_addr_even),
		.mem_write_addr_odd(mem_write_addr_odd),
		.mem_write_data_even(mem_write_data_even),
		.mem_write_data_odd(mem_write_data_odd),
		.mem_write_en_even(mem_write_en_even),
		.mem_write_en_odd(mem_write_en_odd)
	);

	f8_fetch fetch_i (
		.clk(clk),
		.reset(reset),
		.bus(mem_bus.fetch_mp),
		.pc(pc),
		.y(y),
		.next_pc(reg_upd.next_pc),
		.inst(inst),
		.operand(operand),
		.execute(execute)
	);

	f8_execute execute_i (
		.inst(inst),
		.operand(operand),
		.execute(execute),
		.x(x),
		.y(y),
		.pc(pc),
		.f(f),
		.bus(mem_bus.exec_mp),
		.upd(reg_upd.exec_mp),
		.trap(trap)
	);

endmodule

// ==== f8_checker.sv ====
module f8_checker #(
	parameter int EXP_MAX = 64
) (
	input logic clk,
	input logic reset,
	input f8_pkg::bank_addr_t write_addr_even,
	input f8_pkg::bank_addr_t write_addr_odd,
	input f8_pkg::byte_t write_data_even,
	input f8_pkg::byte_t write_data_odd,
	input logic write_en_even,
	input logic write_en_odd,
	input logic trap,
	input f8_pkg::word_t exp_addr [EXP_MAX],
	input f8_pkg::byte_t exp_data [EXP_MAX],
	input int exp_count,
	output int mismatches,
	output int others,
	output int seen
);
	timeunit 1ns;
	timeprecision 1ps;
	import f8_pkg::*;

	logic trap_seen = 1'b0;
	word_t addr_even;
	word_t addr_odd;

	initial
	begin
		mismatches = 0;
		others = 0;
		seen = 0;
	end

	assign addr_even = {write_addr_even, 1'b0};
	assign addr_odd = {write_addr_odd, 1'b1};

	task automatic check_write(input word_t addr, input byte_t data, input string bank);
		if (seen >= exp_count)
		begin
			$display("extra write at %0t: %h written to address %h", $time, data, addr);
			others = others + 1;
		end
		else
		begin
			if (addr !== exp_addr[seen])
			begin
				$display("Mismatch at %0t: mem_write_addr_%s expected %h got %h",
					$time, bank, exp_addr[seen], addr);
				mismatches = mismatches + 1;
			end
			if (data !== exp_data[seen])
			begin
				$display("Mismatch at %0t: mem_write_data_%s expected %h got %h",
					$time, bank, exp_data[seen], data);
				mismatches = mismatches + 1;
			end
		end
		seen = seen + 1;
	endtask

	// a word write in one cycle is compared lower address first
	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (write_en_even && write_en_odd && addr_odd < addr_even)
			begin
				check_write(addr_odd, write_data_odd, "odd");
				check_write(addr_even, write_data_even, "even");
			end
			else
			begin
				if (write_en_even)
					check_write(addr_even, write_data_even, "even");
				if (write_en_odd)
					check_write(addr_odd, write_data_odd, "odd");
			end
			if (trap && !trap_seen)
			begin
				trap_seen <= 1'b1;
				if (seen != exp_count)
				begin
					$display("trap came too early at %0t: only %0d of %0d writes seen",
						$time, seen, exp_count);
					others = others + 1;
				end
			end
		end
	end

endmodule

// ==== f8_core_assert.sv ====
module f8_core_assert (
	input logic clk,
	input logic reset,
	input logic mem_write_en_even,
	input logic mem_write_en_odd,
	input logic trap
);
	timeunit 1ns;
	timeprecision 1ps;

	// the first reset edge only clears the fetch state
	no_write_in_reset: assert property (@(posedge clk)
		reset && $past(reset) |-> !mem_write_en_even && !mem_write_en_odd && !trap)
		else $error("write enable or trap active during reset");

	trap_sticky: assert property (@(posedge clk) disable iff (reset)
		trap |=> trap)
		else $error("trap dropped after it was set");

	no_write_after_trap: assert property (@(posedge clk) disable iff (reset)
		trap |=> !mem_write_en_even && !mem_write_en_odd)
		else $error("memory write after trap was set");

endmodule

bind f8_core f8_core_assert core_assert_i (
	.clk(clk),
	.reset(reset),
	.mem_write_en_even(mem_write_en_even),
	.mem_write_en_odd(mem_write_en_odd),
	.trap(trap)
);

// ==== tb_f8_core.sv ====
module tb_f8_core;
	timeunit 1ns;
	timeprecision 1ps;
	import f8_pkg::*;

	localparam word_t RESET_VECTOR = 16'h4000;
	localparam word_t RES_BASE = 16'h6000;
	localparam int NUM_ROWS = 13;
	localparam int EXP_MAX = 64;

	// test_c selects the carry flag, otherwise zero
	typedef struct {
		opcode_t op;
		byte_t a;
		byte_t b;
		byte_t result;
		logic test_c;
		logic flag;
	} row_t;

	row_t rows [NUM_ROWS] = '{
		'{OP_ADD_XL_IMMD, 8'h12, 8'h34, 8'h46, 1'b0, 1'b0},
		'{OP_ADD_XL_IMMD, 8'hf0, 8'h10, 8'h00, 1'b1, 1'b1},
		'{OP_ADD_XL_IMMD, 8'h80, 8'h80, 8'h00, 1'b0, 1'b1},
		'{OP_SUB_XL_IMMD, 8'h50, 8'h50, 8'h00, 1'b0, 1'b1},
		'{OP_SUB_XL_IMMD, 8'h10, 8'h20, 8'hf0, 1'b1, 1'b0},
		'{OP_AND_XL_IMMD, 8'hf0, 8'h0f, 8'h00, 1'b0, 1'b1},
		'{OP_OR_XL_IMMD, 8'ha0, 8'h05, 8'ha5, 1'b0, 1'b0},
		'{OP_XOR_XL_IMMD, 8'h5a, 8'h5a, 8'h00, 1'b0, 1'b1},
		'{OP_INC_XL, 8'hff, 8'h00, 8'h00, 1'b1, 1'b1},
		'{OP_DEC_XL, 8'h01, 8'h00, 8'h00, 1'b0, 1'b1},
		'{OP_SRL_XL, 8'h81, 8'h00, 8'h40, 1'b1, 1'b1},
		'{OP_SLL_XL, 8'h40, 8'h00, 8'h80, 1'b1, 1'b0},
		'{OP_SLL_XL, 8'h80, 8'h00, 8'h00, 1'b0, 1'b1}
	};

	logic clk = 1'b0;
	logic reset;
	logic trap;
	bank_addr_t read_addr_even;
	bank_addr_t read_addr_odd;
	byte_t read_data_even = 8'h00;
	byte_t read_data_odd = 8'h00;
	bank_addr_t write_addr_even;
	bank_addr_t write_addr_odd;
	byte_t write_data_even;
	byte_t write_data_odd;
	logic write_en_even;
	logic write_en_odd;

	byte_t bank_even [32768];
	byte_t bank_odd [32768];
	word_t exp_addr [EXP_MAX];
	byte_t exp_data [EXP_MAX];
	int exp_count = 0;
	word_t asm_pc;
	int mismatches;
	int others;
	int seen;

	always #20 clk = ~clk;

	always @(posedge clk)
	begin
		read_data_even <= bank_even[read_addr_even];
		read_data_odd <= bank_odd[read_addr_odd];
		if (write_en_even)
			bank_even[write_addr_even] <= write_data_even;
		if (write_en_odd)
			bank_odd[write_addr_odd] <= write_data_odd;
	end

	f8_core #(
		.RESET_VECTOR(RESET_VECTOR)
	) f8_core_i (
		.clk(clk),
		.reset(reset),
		.mem_read_addr_even(read_addr_even),
		.mem_read_addr_odd(read_addr_odd),
		.mem_read_data_even(read_data_even),
		.mem_read_data_odd(read_data_odd),
		.mem_write_addr_even(write_addr_even),
		.mem_write_addr_odd(write_addr_odd),
		.mem_write_data_even(write_data_even),
		.mem_write_data_odd(write_data_odd),
		.mem_write_en_even(write_en_even),
		.mem_write_en_odd(write_en_odd),
		.trap(trap)
	);

	f8_checker #(
		.EXP_MAX(EXP_MAX)
	) checker_i (
		.clk(clk),
		.reset(reset),
		.write_addr_even(write_addr_even),
		.write_addr_odd(write_addr_odd),
		.write_data_even(write_data_even),
		.write_data_odd(write_data_odd),
		.write_en_even(write_en_even),
		.write_en_odd(write_en_odd),
		.trap(trap),
		.exp_addr(exp_addr),
		.exp_data(exp_data),
		.exp_count(exp_count),
		.mismatches(mismatches),
		.others(others),
		.seen(seen)
	);

	task automatic write_byte(input word_t addr, input byte_t value);
		if (addr[0])
			bank_odd[addr[15:1]] = value;
		else
			bank_even[addr[15:1]] = value;
	endtask

	task automatic emit_byte(input byte_t value);
		write_byte(asm_pc, value);
		asm_pc = asm_pc + 16'd1;
	endtask

	task automatic emit_word(input word_t value);
		emit_byte(value[7:0]);
		emit_byte(value[15:8]);
	endtask

	task automatic expect_write(input word_t addr, input byte_t value);
		exp_addr[exp_count] = addr;
		exp_data[exp_count] = value;
		exp_count = exp_count + 1;
	endtask

	task automatic store_xl(input word_t addr, input byte_t value);
		emit_byte(OP_LD_DIR_XL);
		emit_word(addr);
		expect_write(addr, value);
	endtask

	task automatic assemble_row(input int i);
		word_t res;
		res = RES_BASE + word_t'(2 * i);
		emit_byte(OP_LD_XL_IMMD);
		emit_byte(rows[i].a);
		emit_byte(rows[i].op);
		if (!(rows[i].op inside {OP_INC_XL, OP_DEC_XL, OP_SRL_XL, OP_SLL_XL}))
			emit_byte(rows[i].b);
		store_xl(res, rows[i].result);
		emit_byte(OP_LD_XL_IMMD);
		emit_byte(8'h00);
		// skip the inc when the flag is clear
		emit_byte(rows[i].test_c ? OP_JRNC_D : OP_JRNZ_D);
		emit_byte(8'd3);
		emit_byte(OP_INC_XL);
		store_xl(res + 16'd1, {7'b0, rows[i].flag});
	endtask

	task automatic assemble_fixed();
		// data bytes at odd and even addresses
		write_byte(16'h5001, 8'h11);
		write_byte(16'h5002, 8'h22);
		write_byte(16'h5004, 8'h33);
		write_byte(16'h5005, 8'h44);
		emit_byte(OP_LD_XL_IMMD);
		emit_byte(8'h05);
		emit_byte(OP_ADD_XL_DIR);
		emit_word(16'h5001);
		store_xl(16'h6100, 8'h16);
		emit_byte(OP_LD_XL_DIR);
		emit_word(16'h5002);
		store_xl(16'h6101, 8'h22);
		emit_byte(OP_LDW_Y_IMMD);
		emit_word(16'h5005);
		emit_byte(OP_LD_XL_IY);
		store_xl(16'h6102, 8'h44);
		emit_byte(OP_LDW_Y_IMMD);
		emit_word(16'h5004);
		emit_byte(OP_LD_XL_IY);
		emit_byte(OP_LDW_Y_IMMD);
		emit_word(16'h6104);
		emit_byte(OP_LD_IY_XL);
		expect_write(16'h6104, 8'h33);
		// word store at an odd address spans both banks
		emit_byte(OP_LDW_Y_IMMD);
		emit_word(16'h12ff);
		emit_byte(OP_INCW_Y);
		emit_byte(OP_LDW_DIR_Y);
		emit_word(16'h6107);
		expect_write(16'h6107, 8'h00);
		expect_write(16'h6108, 8'h13);
		emit_byte(OP_JP_IMMD);
		emit_word(asm_pc + 16'd4);
		emit_byte(OP_TRAP);
		emit_byte(OP_TRAP);
		emit_byte(OP_LD_XL_IMMD);
		emit_byte(8'h77);
		store_xl(16'h6110, 8'h77);
		emit_byte(OP_JR_D);
		emit_byte(8'd4);
		emit_byte(OP_TRAP);
		emit_byte(OP_TRAP);
		emit_byte(OP_LD_XL_IMMD);
		emit_byte(8'h88);
		store_xl(16'h6111, 8'h88);
		emit_byte(OP_TRAP);
	endtask

	initial
	begin
		int limit;
		int cycles;
		int timeouts;
		reset <= 1'b1;
		timeouts = 0;
		cycles = 0;
		// filler from all word address bits
		for (int a = 0; a < 32768; a++)
		begin
			bank_even[a] = byte_t'(a) ^ byte_t'(a >> 7);
			bank_odd[a] = ~(byte_t'(a) ^ byte_t'(a >> 7));
		end
		asm_pc = RESET_VECTOR;
		for (int i = 0; i < NUM_ROWS; i++)
			assemble_row(i);
		assemble_fixed();
		limit = int'(asm_pc - RESET_VECTOR) * 3 + 50;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		while (!trap && cycles < limit)
		begin
			@(negedge clk);
			cycles = cycles + 1;
		end
		repeat (2) @(negedge clk);
		if (!trap)
		begin
			$display("timeout: trap not reached within %0d cycles", limit);
			timeouts = 1;
		end
		$display("errors: %0d mismatches, %0d other, %0d of %0d writes seen",
			mismatches, others + timeouts, seen, exp_count);
		if (mismatches == 0 && others == 0 && timeouts == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== files.f ====
f8_pkg.sv
f8_ifs.sv
f8_regfile.sv
f8_mem_port.sv
f8_fetch.sv
f8_alu.sv
f8_execute.sv
f8_core.sv
f8_checker.sv
f8_core_assert.sv
tb_f8_core.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS = --binary --timing --assert
TOP = tb_f8_core
FILELIST = files.f
LOG = sim.log

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean
